//--- Makefile
# Verilator build and run for the UART debug server testbench
# Any variable can be overridden, e.g. make simulate OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_uart_debug
FILELIST  ?= uart_debug.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: simulate clean

# A $fatal in the testbench gives a non-zero exit status
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_uart_debug.sv
// Testbench for the UART debug server. Replays host operations from the
// input file over the serial line and checks every reply byte on tx_o.
`timescale 1ns/100ps

module tb_uart_debug import uart_debug_pkg::*; ();

  localparam int REPLY_TIMEOUT = 40 * CLKS_PER_BIT;
  localparam int SILENCE_BITS  = 20;
  localparam int IDLE_CYCLES   = 100;

  logic clk;
  logic reset_i;
  logic rx_i;
  logic tx_o;

  // Host-side memory model and a mark for each byte written so far
  logic [7:0] model_mem [MEM_BYTES];
  bit         written   [MEM_BYTES];
  integer     seed;

  uart_debug_top i_dut (
    .clk     ( clk     ),
    .reset_i ( reset_i ),
    .rx_i    ( rx_i    ),
    .tx_o    ( tx_o    )
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("CHECKS FAILED");
    $fatal(1, "%s", reason);
  endtask

  task automatic compare_value(input logic [7:0] actual, input logic [7:0] expected,
                               input string what);
    if (actual !== expected) begin
      $display("Fail at time %0t: %s, got 8'h%02h, expected 8'h%02h",
               $time, what, actual, expected);
      abort_run("a reply did not match its expected value");
    end
  endtask

  ////////////////////////////////////////
  // Serial line, host side
  ////////////////////////////////////////

  // 8N1 frame sent LSB first with bits changing on falling edges
  task automatic send_byte(input logic [7:0] value);
    logic [9:0] frame;
    frame = {1'b1, value, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      rx_i = frame[i];
      repeat (CLKS_PER_BIT - 1) @(negedge clk);
    end
  endtask

  task automatic send_header(input logic [7:0] cmd, input logic [63:0] addr,
                             input logic [63:0] len);
    send_byte(cmd);
    for (int i = 0; i < HDR_BYTES; i++) begin
      send_byte(addr[8*i +: 8]);
    end
    for (int i = 0; i < HDR_BYTES; i++) begin
      send_byte(len[8*i +: 8]);
    end
  endtask

  task automatic receive_byte(output logic [7:0] value);
    int waited;
    waited = 0;
    value  = '0;
    while (tx_o !== 1'b0 && waited < REPLY_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (tx_o !== 1'b0) begin
      abort_run("no reply byte arrived on tx_o before the timeout");
    end else begin
      // Sample mid start bit and then once per bit time
      repeat (CLKS_PER_BIT / 2) @(negedge clk);
      compare_value({7'd0, tx_o}, 8'd0, "start bit");
      for (int i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        value[i] = tx_o;
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      compare_value({7'd0, tx_o}, 8'd1, "stop bit");
    end
  endtask

  task automatic expect_reply(input logic [7:0] expected, input string what);
    logic [7:0] got;
    receive_byte(got);
    compare_value(got, expected, what);
  endtask

  task automatic expect_silence(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      compare_value({7'd0, tx_o}, 8'd1, "tx_o idle");
    end
  endtask

  ////////////////////////////////////////
  // Host operations
  ////////////////////////////////////////

  task automatic ack_challenge();
    send_byte(BYTE_ACK);
    expect_reply(BYTE_ACK, "ACK challenge");
    // Exactly one byte back
    expect_silence(SILENCE_BITS * CLKS_PER_BIT);
  endtask

  task automatic junk_ignored(input logic [7:0] value);
    send_byte(value);
    expect_silence(SILENCE_BITS * CLKS_PER_BIT);
  endtask

  task automatic write_range(input logic [63:0] addr, input logic [63:0] len);
    logic [LEN_BITS-1:0]      count;
    logic [MEM_ADDR_BITS-1:0] where;
    logic [7:0]               data;
    count = len[LEN_BITS-1:0];
    where = addr[MEM_ADDR_BITS-1:0];
    send_header(CMD_WRITE, addr, len);
    expect_reply(BYTE_ACK, "write ACK");
    for (int i = 0; i < count; i++) begin
      data = 8'($random(seed));
      send_byte(data);
      model_mem[where] = data;
      written[where]   = 1'b1;
      where            = where + 1'b1;
    end
    expect_reply(BYTE_EOT, "write EOT");
  endtask

  task automatic read_range(input logic [63:0] addr, input logic [63:0] len);
    logic [LEN_BITS-1:0]      count;
    logic [MEM_ADDR_BITS-1:0] where;
    count = len[LEN_BITS-1:0];
    where = addr[MEM_ADDR_BITS-1:0];
    send_header(CMD_READ, addr, len);
    expect_reply(BYTE_ACK, "read ACK");
    for (int i = 0; i < count; i++) begin
      if (!written[where]) begin
        abort_run("the input file reads a byte that was never written");
      end else begin
        expect_reply(model_mem[where], $sformatf("read data at 8'h%02h", where));
      end
      where = where + 1'b1;
    end
    expect_reply(BYTE_EOT, "read EOT");
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int          fd;
    int          fields;
    int          ops;
    logic [7:0]  op;
    logic [63:0] addr;
    logic [63:0] len;

    clk     = 1'b0;
    reset_i = 1'b1;
    rx_i    = 1'b1;
    seed    = 32'hf6a0_6c57;
    ops     = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;

    // Nothing to answer yet
    expect_silence(IDLE_CYCLES);

    fd = $fopen("bench/uart_debug_input.txt", "r");
    if (fd == 0) begin
      abort_run("could not open bench/uart_debug_input.txt");
    end
    // Each line is an operation letter and then address and length in hex
    fields = $fscanf(fd, " %c %h %h", op, addr, len);
    while (fields == 3) begin
      case (op)
        "A": ack_challenge();
        "N": junk_ignored(addr[7:0]);
        "W": write_range(addr, len);
        "R": read_range(addr, len);
        default: abort_run("unknown operation letter in the input file");
      endcase
      ops++;
      fields = $fscanf(fd, " %c %h %h", op, addr, len);
    end
    $fclose(fd);

    if (ops == 0) begin
      abort_run("the input file held no operations");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

//--- bench/uart_debug_input.txt
A 0 0
W 10 8
R 10 8
W 40 20
R 44 4
R 10 2
W fc 8
R 0 4
R fc 8
W 0 0
R 40 0
N 55 0
A 0 0
W 100000080 10003
R 80 3
W ffffffffffffff90 4
R 90 4
W 14 2
R 10 8
W 1c 28
R 1c 28
R 40 20
N 4 0
A 0 0

//--- hw/debug_cmd_engine.sv
// Debug protocol engine. Decodes ACK challenges and read/write commands from
// the receiver and sequences memory accesses and reply bytes to the sender.
`timescale 1ns/100ps

module debug_cmd_engine import uart_debug_pkg::*; (
  input  logic                     clk,
  input  logic                     reset_i,
  input  logic                     rx_valid_i,
  input  logic [7:0]               rx_byte_i,
  output logic                     tx_start_o,
  output logic [7:0]               tx_byte_o,
  input  logic                     tx_done_i,
  output logic                     mem_we_o,
  output logic [MEM_ADDR_BITS-1:0] mem_addr_o,
  output logic [7:0]               mem_wdata_o,
  input  logic [7:0]               mem_rdata_i
);

  enum logic [2:0] {S_IDLE, S_ADDR, S_LEN, S_ACK, S_XFER, S_EOT} state_q;

  logic [$clog2(HDR_BYTES)-1:0] hdr_cnt_q;
  logic                         hdr_last;
  logic                         is_write_q;
  logic                         ack_only_q;
  logic                         tx_busy_q;
  logic                         tx_start_q;
  logic [7:0]                   tx_byte_q;
  logic [MEM_ADDR_BITS-1:0]     addr_q;
  logic [LEN_BITS-1:0]          len_q;
  logic                         len_zero;
  logic                         rd_pend_q;
  logic                         buf_valid_q;
  logic [7:0]                   buf_data_q;
  logic                         wr_byte;
  logic                         fetch;
  logic                         send_data;

  assign hdr_last = (hdr_cnt_q == ($clog2(HDR_BYTES))'(HDR_BYTES - 1));
  assign len_zero = (len_q == '0);

  // Write data goes straight from the receiver into memory
  assign wr_byte = (state_q == S_XFER) && is_write_q && rx_valid_i && !len_zero;

  // Read pipeline: fetch, capture into buffer, hand buffer to transmitter
  assign fetch     = (state_q == S_XFER) && !is_write_q && !len_zero &&
                     !rd_pend_q && !buf_valid_q;
  assign send_data = (state_q == S_XFER) && buf_valid_q && !tx_busy_q;

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q     <= S_IDLE;
      hdr_cnt_q   <= '0;
      is_write_q  <= 1'b0;
      ack_only_q  <= 1'b0;
      tx_busy_q   <= 1'b0;
      tx_start_q  <= 1'b0;
      rd_pend_q   <= 1'b0;
      buf_valid_q <= 1'b0;
    end else begin
      tx_start_q <= 1'b0;
      rd_pend_q  <= fetch;
      if (rd_pend_q) begin
        buf_valid_q <= 1'b1;
      end else if (send_data) begin
        buf_valid_q <= 1'b0;
      end
      if (tx_done_i) begin
        tx_busy_q <= 1'b0;
      end

      case (state_q)
        S_IDLE: begin
          // Anything that is not a command is ignored
          if (rx_valid_i) begin
            if (rx_byte_i == CMD_READ || rx_byte_i == CMD_WRITE) begin
              state_q    <= S_ADDR;
              hdr_cnt_q  <= '0;
              is_write_q <= (rx_byte_i == CMD_WRITE);
              ack_only_q <= 1'b0;
            end else if (rx_byte_i == BYTE_ACK) begin
              state_q    <= S_ACK;
              ack_only_q <= 1'b1;
            end
          end
        end
        S_ADDR, S_LEN: begin
          if (rx_valid_i) begin
            if (hdr_last) begin
              hdr_cnt_q <= '0;
              if (state_q == S_ADDR) begin
                state_q <= S_LEN;
              end else begin
                state_q <= S_ACK;
              end
            end else begin
              hdr_cnt_q <= hdr_cnt_q + 1'b1;
            end
          end
        end
        S_ACK: begin
          if (!tx_busy_q) begin
            tx_start_q <= 1'b1;
            tx_busy_q  <= 1'b1;
            if (ack_only_q) begin
              state_q <= S_IDLE;
            end else begin
              state_q <= S_XFER;
            end
          end
        end
        S_XFER: begin
          if (send_data) begin
            tx_start_q <= 1'b1;
            tx_busy_q  <= 1'b1;
          end
          // Done once every byte is counted off and the read pipe is empty
          if (len_zero && !rd_pend_q && !buf_valid_q) begin
            state_q <= S_EOT;
          end
        end
        S_EOT: begin
          if (!tx_busy_q) begin
            tx_start_q <= 1'b1;
            tx_busy_q  <= 1'b1;
            state_q    <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Address, length and data registers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    // Header bytes land LSB first, bits beyond the kept width fall away
    if (state_q == S_ADDR && rx_valid_i) begin
      for (int b = 0; b < MEM_ADDR_BITS; b++) begin
        if (b / 8 == int'(hdr_cnt_q)) addr_q[b] <= rx_byte_i[b % 8];
      end
    end else if (wr_byte || fetch) begin
      addr_q <= addr_q + 1'b1;
    end

    if (state_q == S_LEN && rx_valid_i) begin
      for (int b = 0; b < LEN_BITS; b++) begin
        if (b / 8 == int'(hdr_cnt_q)) len_q[b] <= rx_byte_i[b % 8];
      end
    end else if (wr_byte || fetch) begin
      len_q <= len_q - 1'b1;
    end

    if (rd_pend_q) begin
      buf_data_q <= mem_rdata_i;
    end

    if (state_q == S_ACK) begin
      tx_byte_q <= BYTE_ACK;
    end else if (state_q == S_EOT) begin
      tx_byte_q <= BYTE_EOT;
    end else if (send_data) begin
      tx_byte_q <= buf_data_q;
    end
  end

  assign tx_start_o  = tx_start_q;
  assign tx_byte_o   = tx_byte_q;
  assign mem_we_o    = wr_byte;
  assign mem_addr_o  = addr_q;
  assign mem_wdata_o = rx_byte_i;

endmodule

//--- hw/debug_mem.sv
// Byte-wide debug memory, one synchronous write port and a registered read
// that returns data one cycle after the address.
`timescale 1ns/100ps

module debug_mem import uart_debug_pkg::*; (
  input  logic                     clk,
  input  logic                     we_i,
  input  logic [MEM_ADDR_BITS-1:0] addr_i,
  input  logic [7:0]               wdata_i,
  output logic [7:0]               rdata_o
);

  logic [7:0] mem_q [MEM_BYTES];

  // Contents start undefined
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
    // Old data on a same-address write
    rdata_o <= mem_q[addr_i];
  end

endmodule

//--- hw/uart_debug_pkg.sv
// Shared constants for the UART debug server: protocol bytes, bit timing
// and memory geometry. Modules pull these in with a wildcard import.

package uart_debug_pkg;

  ////////////////////////////////////////
  // Serial line timing
  ////////////////////////////////////////

  // Clock cycles per serial bit, both directions
  localparam int unsigned CLKS_PER_BIT = 16;

  ////////////////////////////////////////
  // Protocol bytes
  ////////////////////////////////////////

  localparam logic [7:0] CMD_READ  = 8'h11;
  localparam logic [7:0] CMD_WRITE = 8'h12;
  localparam logic [7:0] BYTE_ACK  = 8'h06;
  localparam logic [7:0] BYTE_EOT  = 8'h04;

  // Address and length fields are each this many bytes, LSB first
  localparam int unsigned HDR_BYTES = 8;

  ////////////////////////////////////////
  // Memory and transfer sizes
  ////////////////////////////////////////

  // Only the low address bits are kept, higher header bytes are dropped
  localparam int unsigned MEM_ADDR_BITS = 8;
  localparam int unsigned MEM_BYTES     = 1 << MEM_ADDR_BITS;

  // Width of the remaining-length counter
  localparam int unsigned LEN_BITS = 16;

endpackage

//--- hw/uart_debug_top.sv
// UART debug server top level. Serial in and out, the rest is receiver,
// command engine, memory and transmitter wired together.
`timescale 1ns/100ps

module uart_debug_top import uart_debug_pkg::*; (
  input  logic clk,
  input  logic reset_i,
  input  logic rx_i,
  output logic tx_o
);

  logic                     rx_valid;
  logic [7:0]               rx_byte;
  logic                     tx_start;
  logic [7:0]               tx_byte;
  logic                     tx_done;
  logic                     mem_we;
  logic [MEM_ADDR_BITS-1:0] mem_addr;
  logic [7:0]               mem_wdata;
  logic [7:0]               mem_rdata;

  uart_rx i_uart_rx (
    .clk        ( clk      ),
    .reset_i    ( reset_i  ),
    .rx_i       ( rx_i     ),
    .rx_valid_o ( rx_valid ),
    .rx_byte_o  ( rx_byte  )
  );

  debug_cmd_engine i_engine (
    .clk         ( clk       ),
    .reset_i     ( reset_i   ),
    .rx_valid_i  ( rx_valid  ),
    .rx_byte_i   ( rx_byte   ),
    .tx_start_o  ( tx_start  ),
    .tx_byte_o   ( tx_byte   ),
    .tx_done_i   ( tx_done   ),
    .mem_we_o    ( mem_we    ),
    .mem_addr_o  ( mem_addr  ),
    .mem_wdata_o ( mem_wdata ),
    .mem_rdata_i ( mem_rdata )
  );

  debug_mem i_mem (
    .clk     ( clk       ),
    .we_i    ( mem_we    ),
    .addr_i  ( mem_addr  ),
    .wdata_i ( mem_wdata ),
    .rdata_o ( mem_rdata )
  );

  uart_tx i_uart_tx (
    .clk        ( clk      ),
    .reset_i    ( reset_i  ),
    .tx_start_i ( tx_start ),
    .tx_byte_i  ( tx_byte  ),
    .tx_o       ( tx_o     ),
    .tx_done_o  ( tx_done  )
  );

endmodule

//--- hw/uart_rx.sv
// Serial receiver for 8N1 frames. Emits one byte strobe per good frame,
// frames with a low stop bit are dropped.
`timescale 1ns/100ps

module uart_rx import uart_debug_pkg::*; (
  input  logic       clk,
  input  logic       reset_i,
  input  logic       rx_i,
  output logic       rx_valid_o,
  output logic [7:0] rx_byte_o
);

  enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_q;

  logic                            rx_meta_q;
  logic                            rx_sync_q;
  logic                            rx_prev_q;
  logic [$clog2(CLKS_PER_BIT)-1:0] clk_cnt_q;
  logic [2:0]                      bit_idx_q;
  logic [7:0]                      shift_q;
  logic                            valid_q;

  // Two-flop synchronizer plus one flop for edge detection
  always_ff @(posedge clk) begin
    if (reset_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      rx_prev_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
      rx_prev_q <= rx_sync_q;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q   <= S_IDLE;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state_q)
        S_IDLE: begin
          // Falling edge, wait half a bit to land mid start bit
          if (rx_prev_q && !rx_sync_q) begin
            state_q   <= S_START;
            clk_cnt_q <= ($clog2(CLKS_PER_BIT))'(CLKS_PER_BIT / 2 - 1);
          end
        end
        S_START: begin
          if (clk_cnt_q == '0) begin
            if (!rx_sync_q) begin
              state_q   <= S_DATA;
              clk_cnt_q <= ($clog2(CLKS_PER_BIT))'(CLKS_PER_BIT - 1);
              bit_idx_q <= '0;
            end else begin
              // Line went back high, just a glitch
              state_q <= S_IDLE;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q - 1'b1;
          end
        end
        S_DATA: begin
          if (clk_cnt_q == '0) begin
            clk_cnt_q <= ($clog2(CLKS_PER_BIT))'(CLKS_PER_BIT - 1);
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              state_q <= S_STOP;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q - 1'b1;
          end
        end
        S_STOP: begin
          if (clk_cnt_q == '0) begin
            state_q <= S_IDLE;
            valid_q <= rx_sync_q;
          end else begin
            clk_cnt_q <= clk_cnt_q - 1'b1;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (state_q == S_DATA && clk_cnt_q == '0) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
  end

  assign rx_valid_o = valid_q;
  assign rx_byte_o  = shift_q;

endmodule

//--- hw/uart_tx.sv
// Serial transmitter for 8N1 frames. A start strobe while idle sends one
// byte, done pulses in the last cycle of the stop bit.
`timescale 1ns/100ps

module uart_tx import uart_debug_pkg::*; (
  input  logic       clk,
  input  logic       reset_i,
  input  logic       tx_start_i,
  input  logic [7:0] tx_byte_i,
  output logic       tx_o,
  output logic       tx_done_o
);

  logic                            busy_q;
  logic [$clog2(CLKS_PER_BIT)-1:0] clk_cnt_q;
  logic [3:0]                      bit_idx_q;
  logic [8:0]                      shift_q;
  logic                            tx_q;
  logic                            bit_end;

  // Bit index 0 is the start bit, 1 to 8 data, 9 the stop bit
  assign bit_end   = busy_q && (clk_cnt_q == '0);
  assign tx_done_o = bit_end && (bit_idx_q == 4'd9);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      busy_q    <= 1'b0;
      tx_q      <= 1'b1;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
    end else if (!busy_q) begin
      if (tx_start_i) begin
        busy_q    <= 1'b1;
        tx_q      <= 1'b0;
        clk_cnt_q <= ($clog2(CLKS_PER_BIT))'(CLKS_PER_BIT - 1);
        bit_idx_q <= '0;
      end
    end else if (bit_end) begin
      clk_cnt_q <= ($clog2(CLKS_PER_BIT))'(CLKS_PER_BIT - 1);
      if (bit_idx_q == 4'd9) begin
        busy_q <= 1'b0;
      end else begin
        bit_idx_q <= bit_idx_q + 1'b1;
        tx_q      <= shift_q[0];
      end
    end else begin
      clk_cnt_q <= clk_cnt_q - 1'b1;
    end
  end

  // Stop bit rides on top of the data, ones fill in behind it
  always_ff @(posedge clk) begin
    if (!busy_q && tx_start_i) begin
      shift_q <= {1'b1, tx_byte_i};
    end else if (bit_end) begin
      shift_q <= {1'b1, shift_q[8:1]};
    end
  end

  assign tx_o = tx_q;

endmodule

//--- uart_debug.f
hw/uart_debug_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/debug_cmd_engine.sv
hw/debug_mem.sv
hw/uart_debug_top.sv
bench/tb_uart_debug.sv
